// ==== ca_code/ca_code_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module ca_code_gen (
   input  wire             gps_data,
   input  wire             rst,
   input  wire gps_pkg::prn_t prn,
   input  wire             code_restart,
   input  wire             code_advance,
   output logic            ca_chip
);

   logic [10:1] g1;          // G1 LFSR, stage 1 takes feedback
   logic [10:1] g2;          // G2 LFSR
   logic [4:0]  prn_q;       // PRN latched on restart
   logic [7:0]  taps;        // Two G2 stage numbers
   logic [3:0]  tap_a;
   logic [3:0]  tap_b;

   always_ff @(posedge gps_data) begin
      if (rst) begin
         g1    <= '1;
         g2    <= '1;
         prn_q <= '0;
      end else if (code_restart) begin
         g1    <= '1;         // Both registers start at all ones
         g2    <= '1;
         prn_q <= prn;        // Host holds prn stable during req
      end else if (code_advance) begin
         g1 <= {g1[9:1], g1[3] ^ g1[10]};
         g2 <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   end

   // Phase select taps per ICD table, index is PRN minus 1
   always_comb begin
      case (prn_q)
         5'd0:    taps = {4'd2, 4'd6};
         5'd1:    taps = {4'd3, 4'd7};
         5'd2:    taps = {4'd4, 4'd8};
         5'd3:    taps = {4'd5, 4'd9};
         5'd4:    taps = {4'd1, 4'd9};
         5'd5:    taps = {4'd2, 4'd10};
         5'd6:    taps = {4'd1, 4'd8};
         5'd7:    taps = {4'd2, 4'd9};
         5'd8:    taps = {4'd3, 4'd10};
         5'd9:    taps = {4'd2, 4'd3};
         5'd10:   taps = {4'd3, 4'd4};
         5'd11:   taps = {4'd5, 4'd6};
         5'd12:   taps = {4'd6, 4'd7};
         5'd13:   taps = {4'd7, 4'd8};
         5'd14:   taps = {4'd8, 4'd9};
         5'd15:   taps = {4'd9, 4'd10};
         5'd16:   taps = {4'd1, 4'd4};
         5'd17:   taps = {4'd2, 4'd5};
         5'd18:   taps = {4'd3, 4'd6};
         5'd19:   taps = {4'd4, 4'd7};
         5'd20:   taps = {4'd5, 4'd8};
         5'd21:   taps = {4'd6, 4'd9};
         5'd22:   taps = {4'd1, 4'd3};
         5'd23:   taps = {4'd4, 4'd6};
         5'd24:   taps = {4'd5, 4'd7};
         5'd25:   taps = {4'd6, 4'd8};
         5'd26:   taps = {4'd7, 4'd9};
         5'd27:   taps = {4'd8, 4'd10};
         5'd28:   taps = {4'd1, 4'd6};
         5'd29:   taps = {4'd2, 4'd7};
         5'd30:   taps = {4'd3, 4'd8};
         default: taps = {4'd4, 4'd9};   // PRN 32
      endcase
   end

   assign tap_a = taps[7:4];
   assign tap_b = taps[3:0];

   assign ca_chip = g1[10] ^ g2[tap_a] ^ g2[tap_b];   // Gold code chip

endmodule

`default_nettype wire

// ==== common/gps_defs.svh ====
`ifndef GPS_DEFS_SVH
`define GPS_DEFS_SVH

// C/A code period in chips, also the dwell length in samples
`define CA_CODE_LEN 1023

// Code shift width, covers 0 to 1022
`define SHIFT_W 10

// Signed correlation accumulator width
`define ACC_W 16

// Highest satellite PRN handled by the G2 tap table
`define PRN_MAX 32

`endif

// ==== common/gps_pkg.sv ====
`default_nettype none

`include "gps_defs.svh"

package gps_pkg;

   typedef logic [$clog2(`PRN_MAX)-1:0] prn_t;         // PRN minus 1
   typedef logic [2:0]                  sample_t;      // Sign in bit 2, magnitude in 1:0
   typedef logic [`SHIFT_W-1:0]         chip_shift_t;  // Code phase trial index
   typedef logic signed [`ACC_W-1:0]    accum_t;       // Correlation sum

   // Search sequencing
   typedef enum logic [2:0] {
      IDLE,     // Waiting for req
      START,    // Code restart and clears
      DWELL,    // Accepting samples for one period
      SLIP,     // Extra code advance
      COMPARE,  // Commit trial result
      DONE      // ack high until req drops
   } search_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_gps_search \
   -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_gps_search > sim.log 2>&1
cat sim.log

grep -qx "Verification passed" sim.log && echo "Simulation PASS" || {
   echo "Simulation FAIL"
   exit 1
}

// ==== tb.f ====
+incdir+common
common/gps_pkg.sv
ca_code/ca_code_gen.sv
verilog/chip_timer.sv
verilog/search_fsm.sv
verilog/correlator.sv
verilog/gps_search_top.sv
tb/gps_search_assert.sv
tb/tb_gps_search.sv

// ==== tb/gps_search_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module gps_search_assert (
   input wire gps_data,
   input wire rst,
   input wire req,
   input wire ack,
   input wire sample_ready
);

   // ack only answers a pending request
   a_ack_rise: assert property (@(posedge gps_data) disable iff (rst) $rose(ack) |-> req)
      else $error("ack rose while req was low");

   // Result held until the host lets go
   a_ack_hold: assert property (@(posedge gps_data) disable iff (rst) (ack && req) |=> ack)
      else $error("ack fell while req was still high");

   a_no_ready: assert property (@(posedge gps_data) disable iff (rst) ack |-> !sample_ready)
      else $error("sample_ready high while ack was high");   // Stream stalled in DONE

endmodule

bind gps_search_top gps_search_assert u_assert (
   .gps_data     (gps_data),
   .rst          (rst),
   .req          (req),
   .ack          (ack),
   .sample_ready (sample_ready)
);

`default_nettype wire

// ==== tb/tb_gps_search.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gps_defs.svh"

module tb_gps_search;

   import gps_pkg::*;

   localparam int L       = `CA_CODE_LEN;
   localparam int MAX_SMP = 8 * `CA_CODE_LEN;   // Room for seven trials plus one
   // G2 phase select per ICD, high nibble first tap, index PRN minus 1
   localparam logic [7:0] G2_SEL [32] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2A, 8'h18, 8'h29,
      8'h3A, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9A,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8A, 8'h16, 8'h27, 8'h38, 8'h49};

   logic gps_data;
   logic rst;
   logic req;
   prn_t prn;
   chip_shift_t max_shift;
   logic ack;
   logic sample_valid;
   sample_t sample;
   logic sample_ready;
   logic ca_bit;
   chip_shift_t best_shift;
   accum_t best_accum;

   logic [31:0]  lcg_state = 32'h5587;
   logic [L-1:0] code;                  // Reference chips, bit i is chip i
   sample_t      samp [MAX_SMP];        // Stream indexed by transfer count k
   logic [9:0]   first10;               // First chips seen in trial 0
   chip_shift_t  exp_shift;
   accum_t       exp_acc;
   accum_t       first_acc;

   gps_search_top dut (.*);

   initial begin
      gps_data = 1'b0;
      forever #2 gps_data = ~gps_data;   // 4 ns period
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Full C/A period from the G1/G2 rule, PRN 1 to 32
   function automatic logic [L-1:0] ca_ref(input int prn_num);
      logic [10:1] g1;
      logic [10:1] g2;
      logic [7:0]  sel;
      logic [L-1:0] seq;
      int i;
      g1  = '1;
      g2  = '1;
      sel = G2_SEL[prn_num - 1];
      for (i = 0; i < L; i++) begin
         seq[i] = g1[10] ^ g2[sel[7:4]] ^ g2[sel[3:0]];
         g1 = {g1[9:1], ^(g1 & 10'b1000000100)};   // Taps 3 and 10
         g2 = {g2[9:1], ^(g2 & 10'b1110100110)};   // Taps 2 3 6 8 9 10
      end
      return seq;
   endfunction

   task automatic report_fail(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         report_fail($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // flip_mode 0 none, 1 about one in eight
   task automatic fill_samples(input int n, input int offset, input int flip_mode);
      logic [31:0] r;
      logic        f;
      int k;
      for (k = 0; k < n; k++) begin
         r = lcg_next();
         f = (flip_mode == 1) ? (r[30:28] == 3'd0) : 1'b0;
         samp[k] = {code[(k + offset) % L] ^ f, r[17:16]};
      end
   endtask

   // Gives trial dst the same products as trial src, aligned at shift src
   task automatic copy_trial(input int src, input int dst);
      logic f;
      int j;
      for (j = 0; j < L; j++) begin
         f = samp[src * L + j][2] ^ code[(j + src) % L];
         samp[dst * L + j] = {code[(j + dst) % L] ^ f, samp[src * L + j][1:0]};
      end
   endtask

   // Per trial sum, lowest shift wins ties
   task automatic model_search(input int ms);
      int s;
      int j;
      int sum;
      int lvl;
      int best;
      best = -(1 << 30);
      for (s = 0; s <= ms; s++) begin
         sum = 0;
         for (j = 0; j < L; j++) begin
            lvl = 2 * samp[s * L + j][1:0] + 1;
            sum = (samp[s * L + j][2] ^ code[(j + s) % L]) ? sum - lvl : sum + lvl;
         end
         if (sum > best) begin
            best      = sum;
            exp_shift = chip_shift_t'(s);
         end
      end
      exp_acc = accum_t'(best);
   endtask

   // Starts 0.5 ns after an edge and returns aligned the same way
   task automatic run_search(input int prn_num, input int ms, input bit gaps, input int hold);
      logic [31:0] r;
      int k;
      int cycles;
      int limit;
      bit took;
      bit done;
      limit        = 4 * (ms + 1) * (L + 2) + 100;
      prn          = prn_t'(prn_num - 1);
      max_shift    = chip_shift_t'(ms);
      req          = 1'b1;
      sample_valid = 1'b1;
      sample       = samp[0];
      k            = 0;
      cycles       = 0;
      done         = 1'b0;
      while (!done) begin
         #3;                                          // Just before the next edge
         if (ack) begin
            done = 1'b1;
         end else begin
            took = sample_valid && sample_ready;
            if (took) begin
               check_val("ca_bit", ca_bit, code[(k % L + k / L) % L]);
               if (k < 10) first10 = {first10[8:0], ca_bit};
            end
            @(posedge gps_data);
            #0.5;
            if (took) k++;
            cycles++;
            if (cycles > limit) report_fail("Timeout waiting for ack to rise");
            r            = lcg_next();
            sample_valid = gaps ? (r[27:26] != 2'd0) : 1'b1;
            sample       = sample_valid ? samp[k] : sample_t'(r[12:10]);   // Junk when idle
         end
      end
      check_val("transfers", k, (ms + 1) * L);
      if (!gaps) check_val("search_cycles", cycles, 2 + (ms + 1) * (L + 2));
      check_val("sample_ready", sample_ready, 0);
      check_val("best_shift", best_shift, exp_shift);
      check_val("best_accum", best_accum, exp_acc);
      repeat (hold) begin
         @(posedge gps_data);
         #3.5;
         check_val("ack", ack, 1);
         check_val("best_shift", best_shift, exp_shift);   // Held while req high
         check_val("best_accum", best_accum, exp_acc);
      end
      @(posedge gps_data);
      #0.5;
      req    = 1'b0;
      cycles = 0;
      #3;
      while (ack) begin
         @(posedge gps_data);
         #3.5;
         cycles++;
         if (cycles > 10) report_fail("Timeout waiting for ack to fall after req dropped");
      end
      check_val("ack_fall_cycles", cycles, 1);
      @(posedge gps_data);
      #0.5;
   endtask

   task automatic test_reset();
      #3;
      check_val("ack", ack, 0);
      check_val("sample_ready", sample_ready, 0);
      check_val("best_shift", best_shift, 0);
      check_val("best_accum", best_accum, 0);
      @(posedge gps_data);
      #0.5;
   endtask

   task automatic test_code_prn1();
      code = ca_ref(1);
      fill_samples(L, 0, 0);
      model_search(0);
      run_search(1, 0, 1'b0, 1);
      check_val("ca_bit_first10", first10, 10'b1100100000);   // ICD octal 1440
   endtask

   task automatic test_clean();
      int j;
      int sum;
      code = ca_ref(5);
      fill_samples(7 * L, 3, 0);
      sum = 0;
      for (j = 0; j < L; j++) sum += 2 * samp[3 * L + j][1:0] + 1;
      exp_shift = chip_shift_t'(3);        // Perfect match at the offset
      exp_acc   = accum_t'(sum);
      run_search(5, 6, 1'b0, 1);           // ca_bit checked against the reference per transfer
   endtask

   task automatic test_noisy_tie();
      code = ca_ref(17);
      fill_samples(7 * L, 2, 1);
      copy_trial(2, 5);                    // Equal peaks at shifts 2 and 5
      model_search(6);
      run_search(17, 6, 1'b0, 1);
   endtask

   task automatic test_backpressure();
      code = ca_ref(23);
      fill_samples(6 * L, 4, 1);
      model_search(5);
      run_search(23, 5, 1'b1, 1);
   endtask

   task automatic test_handshake();
      code = ca_ref(11);
      fill_samples(4 * L, 1, 1);
      model_search(3);
      first_acc = exp_acc;
      run_search(11, 3, 1'b0, 20);
      code = ca_ref(30);                   // Same stream, other satellite
      model_search(3);
      if (exp_acc >= first_acc) report_fail("Second request peak not below the first");
      run_search(30, 3, 1'b0, 1);
   endtask

   initial begin
      rst          = 1'b1;
      req          = 1'b0;
      prn          = '0;
      max_shift    = '0;
      sample_valid = 1'b0;
      sample       = '0;
      first10      = '0;
      repeat (10) @(posedge gps_data);
      #0.5;
      rst = 1'b0;
      test_reset();
      test_code_prn1();
      test_clean();
      test_noisy_tie();
      test_backpressure();
      test_handshake();
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/chip_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gps_defs.svh"

module chip_timer (
   input  wire                      gps_data,
   input  wire                      rst,
   input  wire                      timer_clear,
   input  wire                      chip_step,
   input  wire                      shift_step,
   input  wire gps_pkg::chip_shift_t max_shift,
   output gps_pkg::chip_shift_t      trial_shift,
   output logic                     dwell_end,
   output logic                     last_shift
);

   import gps_pkg::*;

   logic [`SHIFT_W-1:0] chip_cnt;    // Transfers so far in this dwell
   chip_shift_t         max_q;       // Last trial of this request
   logic                chip_wrap;

   assign chip_wrap = (chip_cnt == `SHIFT_W'(`CA_CODE_LEN - 1));

   always_ff @(posedge gps_data) begin
      if (rst) begin
         chip_cnt    <= '0;
         trial_shift <= '0;
         max_q       <= '0;
      end else if (timer_clear) begin
         chip_cnt    <= '0;
         trial_shift <= '0;
         max_q       <= max_shift;    // Captured as the search starts
      end else begin
         if (chip_step) begin
            chip_cnt <= chip_wrap ? '0 : chip_cnt + 1'b1;
         end
         if (shift_step) begin
            trial_shift <= trial_shift + 1'b1;
         end
      end
   end

   assign dwell_end  = chip_step & chip_wrap;        // Transfer of chip 1022
   assign last_shift = (trial_shift == max_q);

endmodule

`default_nettype wire

// ==== verilog/correlator.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gps_defs.svh"

module correlator (
   input  wire                      gps_data,
   input  wire                      rst,
   input  wire gps_pkg::sample_t     sample,
   input  wire                      ca_chip,
   input  wire                      acc_clear,
   input  wire                      acc_enable,
   input  wire                      acc_commit,
   input  wire gps_pkg::chip_shift_t trial_shift,
   output gps_pkg::chip_shift_t      best_shift,
   output gps_pkg::accum_t           best_accum
);

   import gps_pkg::*;

   localparam accum_t ACC_MIN = {1'b1, {(`ACC_W - 1){1'b0}}};   // Most negative

   logic [2:0] level;     // 2m+1, always odd
   logic       negate;    // Sample sign times chip sign
   accum_t     term;
   accum_t     acc_sum;   // Running sum for the current trial

   assign level  = {sample[1:0], 1'b1};
   assign negate = sample[2] ^ ca_chip;             // Chip 1 means -1
   assign term   = negate ? -accum_t'(level) : accum_t'(level);

   // Trial sum, restarted at request start and after each commit
   always_ff @(posedge gps_data) begin
      if (acc_clear || acc_commit) begin
         acc_sum <= '0;
      end else if (acc_enable) begin
         acc_sum <= acc_sum + term;                 // Same edge as the transfer
      end
   end

   always_ff @(posedge gps_data) begin
      if (rst) begin
         best_accum <= '0;
         best_shift <= '0;
      end else if (acc_clear) begin
         best_accum <= ACC_MIN;                     // First trial always wins
         best_shift <= '0;
      end else if (acc_commit && (acc_sum > best_accum)) begin
         best_accum <= acc_sum;                     // Strictly greater keeps lowest shift
         best_shift <= trial_shift;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/gps_search_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module gps_search_top (
   input  wire                      gps_data,
   input  wire                      rst,
   input  wire                      req,
   input  wire gps_pkg::prn_t        prn,
   input  wire gps_pkg::chip_shift_t max_shift,
   output logic                     ack,
   input  wire                      sample_valid,
   input  wire gps_pkg::sample_t     sample,
   output logic                     sample_ready,
   output logic                     ca_bit,
   output gps_pkg::chip_shift_t      best_shift,
   output gps_pkg::accum_t           best_accum
);

   import gps_pkg::*;

   logic        code_restart;
   logic        code_advance;
   logic        timer_clear;
   logic        chip_step;
   logic        shift_step;
   logic        acc_clear;
   logic        acc_enable;
   logic        acc_commit;
   logic        dwell_end;
   logic        last_shift;
   logic        ca_chip;
   chip_shift_t trial_shift;   // Current code phase trial

   // Local Gold code
   ca_code_gen u_code (
      .gps_data     (gps_data),
      .rst          (rst),
      .prn          (prn),
      .code_restart (code_restart),
      .code_advance (code_advance),
      .ca_chip      (ca_chip)
   );

   // Dwell and trial counters
   chip_timer u_timer (
      .gps_data    (gps_data),
      .rst         (rst),
      .timer_clear (timer_clear),
      .chip_step   (chip_step),
      .shift_step  (shift_step),
      .max_shift   (max_shift),
      .trial_shift (trial_shift),
      .dwell_end   (dwell_end),
      .last_shift  (last_shift)
   );

   search_fsm u_fsm (
      .gps_data     (gps_data),
      .rst          (rst),
      .req          (req),
      .ack          (ack),
      .sample_valid (sample_valid),
      .sample_ready (sample_ready),
      .dwell_end    (dwell_end),
      .last_shift   (last_shift),
      .code_restart (code_restart),
      .code_advance (code_advance),
      .timer_clear  (timer_clear),
      .chip_step    (chip_step),
      .shift_step   (shift_step),
      .acc_clear    (acc_clear),
      .acc_enable   (acc_enable),
      .acc_commit   (acc_commit)
   );

   // Accumulate and keep the peak
   correlator u_corr (
      .gps_data    (gps_data),
      .rst         (rst),
      .sample      (sample),
      .ca_chip     (ca_chip),
      .acc_clear   (acc_clear),
      .acc_enable  (acc_enable),
      .acc_commit  (acc_commit),
      .trial_shift (trial_shift),
      .best_shift  (best_shift),
      .best_accum  (best_accum)
   );

   assign ca_bit = ca_chip;   // Local code for observation

endmodule

`default_nettype wire

// ==== verilog/search_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module search_fsm (
   input  wire  gps_data,
   input  wire  rst,
   input  wire  req,
   output logic ack,
   input  wire  sample_valid,
   output logic sample_ready,
   input  wire  dwell_end,
   input  wire  last_shift,
   output logic code_restart,
   output logic code_advance,
   output logic timer_clear,
   output logic chip_step,
   output logic shift_step,
   output logic acc_clear,
   output logic acc_enable,
   output logic acc_commit
);

   import gps_pkg::*;

   search_state_t state;
   search_state_t state_nxt;
   logic          xfer;          // Sample accepted this edge
   logic          in_start;
   logic          in_compare;

   always_ff @(posedge gps_data) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (req) begin
               state_nxt = START;   // ack is always low here
            end
         end
         START: begin
            state_nxt = DWELL;
         end
         DWELL: begin
            if (dwell_end) begin
               state_nxt = SLIP;    // Last chip of the period taken
            end
         end
         SLIP: begin
            state_nxt = COMPARE;
         end
         COMPARE: begin
            state_nxt = last_shift ? DONE : DWELL;
         end
         DONE: begin
            if (!req) begin
               state_nxt = IDLE;    // ack drops on this edge
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   assign in_start   = (state == START);
   assign in_compare = (state == COMPARE);

   // Stream side, ready only while dwelling
   assign sample_ready = (state == DWELL);
   assign xfer         = sample_ready & sample_valid;

   // Host side
   assign ack = (state == DONE);

   assign code_restart = in_start;
   assign timer_clear  = in_start;
   assign acc_clear    = in_start;

   assign code_advance = xfer | (state == SLIP);   // Extra advance gives the slip
   assign chip_step    = xfer;
   assign acc_enable   = xfer;

   assign acc_commit = in_compare;
   assign shift_step = in_compare & ~last_shift;   // Next trial

endmodule

`default_nettype wire
